// File: Makefile
# Verilator build and run for the data memory testbench

VERILATOR ?= verilator
TOP       ?= tb_data_mem
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= No errors

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
verilog/dmem_pkg.sv
verilog/dmem_lane_if.sv
verilog/dmem_load_if.sv
verilog/dmem_store_align.sv
verilog/dmem_bank.sv
verilog/dmem_load_format.sv
verilog/data_mem.sv
tests/data_mem_assert.sv
tests/tb_data_mem.sv

// File: tests/data_mem_assert.sv
// Protocol and timing assertions for the data memory, bound into the top level
`timescale 1ns/1ns
`default_nettype none

module data_mem_assert (
  input logic        clk,
  input logic        arst_n,
  input logic        rd_en,
  input logic        wr_en,
  input logic        rvalid,
  input logic        fault,
  input logic [31:0] rdata,
  input logic [3:0]  we_mask
);

  int fail_count = 0;

  // --------------------
  // Request side
  // --------------------

  // Core never loads and stores in the same cycle
  a_single_req: assert property (@(posedge clk) !(rd_en && wr_en))
  else begin
    fail_count++;
    $error("rd_en and wr_en high together");
  end

  // --------------------
  // Response timing
  // --------------------

  // Request sampled at edge N shows up after edge N+1
  a_rvalid_delay: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid == $past(rd_en, 2))
  else begin
    fail_count++;
    $error("rvalid does not follow rd_en by one cycle");
  end

  // A refused request never touched a lane
  a_fault_no_write: assert property (@(posedge clk) disable iff (!arst_n)
    fault |-> ($past(we_mask, 2) == 4'b0000))
  else begin
    fail_count++;
    $error("fault raised on a request that wrote the RAM");
  end

  // Outputs come out of reset quiet
  a_reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> (!rvalid && !fault && rdata == 32'h0))
  else begin
    fail_count++;
    $error("rvalid, fault or rdata not cleared by reset");
  end

endmodule

bind data_mem data_mem_assert u_assert (
  .clk     (clk),
  .arst_n  (arst_n),
  .rd_en   (rd_en),
  .wr_en   (wr_en),
  .rvalid  (rvalid),
  .fault   (fault),
  .rdata   (rdata),
  .we_mask (lane_if.we_mask)
);

`default_nettype wire

// File: tests/tb_data_mem.sv
// Testbench for the RV32 data memory
// Directed and random loads and stores checked against a byte-array model
`timescale 1ns/1ns
`default_nettype none

module tb_data_mem;

  localparam logic [31:0] base = 32'h8000_2000;
  localparam int words = 64;
  localparam int nbytes = 4 * words;
  localparam int rw = $clog2(nbytes);
  localparam int n_directed = 68;
  localparam int n_random = 400;
  // Twice the request count, with room for reset and drain
  localparam int limit = 2 * (n_directed + n_random + 32);
  localparam logic [31:0] fault_word = 32'hABCD_EF12;

  logic clk;
  logic arst_n;
  logic rd_en;
  logic wr_en;
  logic [2:0] fn3;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic rvalid;
  logic fault;

  // Reference byte array, with a flag per byte once it is written
  logic [7:0] model [nbytes];
  logic known [nbytes];
  logic [31:0] exp_q [$];
  logic [31:0] mask_q [$];
  logic exp_fault_q [$];
  int errors = 0;
  int st_faults = 0;
  int st_faults_seen = 0;
  int cycles = 0;
  int seed;
  logic [31:0] r;
  logic [31:0] d;
  logic [31:0] a;

  data_mem #(
    .base_addr   (base),
    .depth_words (words)
  ) uut (
    .clk    (clk),
    .arst_n (arst_n),
    .rd_en  (rd_en),
    .wr_en  (wr_en),
    .fn3    (fn3),
    .addr   (addr),
    .wdata  (wdata),
    .rdata  (rdata),
    .rvalid (rvalid),
    .fault  (fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  // One request per cycle; the model and expected results follow the RISC-V rules
  task automatic issue(input logic wr, input logic [2:0] f, input logic [31:0] adr,
                       input logic [31:0] dat);
    logic [31:0] off;
    logic [31:0] val;
    logic [31:0] m;
    logic [rw-1:0] bi;
    int size;
    logic ok;
    @(posedge clk);
    #1;
    rd_en = ~wr;
    wr_en = wr;
    fn3 = f;
    addr = adr;
    wdata = dat;
    off = adr - base;
    size = (f[1:0] == 2'b00) ? 1 : ((f[1:0] == 2'b01) ? 2 : 4);
    // Codes 011, 110, 111 are reserved, and stores have no unsigned forms
    ok = (f != 3'b011) && (f[2:1] != 2'b11) && !(wr && f[2]);
    ok = ok && (off < nbytes) && (off % size == 0);
    val = '0;
    m = '0;
    for (int i = 0; i < size; i++) begin
      bi = off[rw-1:0] + rw'(i);
      if (wr && ok) begin
        model[bi] = dat[8*i +: 8];
        known[bi] = 1'b1;
      end
      val[8*i +: 8] = model[bi];
      m[8*i +: 8] = {8{known[bi]}};
    end
    // Upper bits copy the sign bit, or are zero for BU and HU
    for (int b = 8; b < 32; b++) begin
      if (b >= 8 * size) begin
        val[b] = f[2] ? 1'b0 : val[8*size-1];
        m[b] = f[2] | m[8*size-1];
      end
    end
    if (!wr) begin
      exp_q.push_back(ok ? val : fault_word);
      mask_q.push_back(ok ? m : 32'hFFFF_FFFF);
      exp_fault_q.push_back(!ok);
    end else if (!ok) begin
      st_faults++;
    end
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    rd_en = 1'b0;
    wr_en = 1'b0;
  endtask

  // --------------------
  // Response checks
  // --------------------

  task automatic check_load();
    logic [31:0] e;
    logic [31:0] m;
    logic ef;
    a_load_pending: assert (exp_q.size() > 0) else begin
      errors++;
      $display("Error at %0t: rvalid with no load outstanding", $time);
    end
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      m = mask_q.pop_front();
      ef = exp_fault_q.pop_front();
      a_load_data: assert ((rdata & m) == (e & m)) else begin
        errors++;
        $display("Error at %0t: rdata %h, expected %h under mask %h", $time, rdata, e, m);
      end
      a_load_fault: assert (fault == ef) else begin
        errors++;
        $display("Error at %0t: load fault %b, expected %b", $time, fault, ef);
      end
    end
  endtask

  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge clk) begin
    if (arst_n && rvalid) begin
      check_load();
    end else if (arst_n && fault) begin
      st_faults_seen++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    seed = 32'hbc5a;
    arst_n = 1'b0;
    rd_en = 1'b0;
    wr_en = 1'b0;
    fn3 = 3'b000;
    addr = '0;
    wdata = '0;
    known = '{default: 1'b0};
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;

    // Word store then word load in the next cycle, last word included
    for (int i = 0; i < 4; i++) begin
      issue(1'b1, 3'b010, base + 32'(8 * i), 32'hC0DE_0000 | 32'(i));
      issue(1'b0, 3'b010, base + 32'(8 * i), '0);
    end
    issue(1'b1, 3'b010, base + 32'(nbytes - 4), 32'h0F1E_2D3C);
    issue(1'b0, 3'b010, base + 32'(nbytes - 4), '0);

    // Byte and halfword stores at every legal offset
    issue(1'b1, 3'b010, base + 32'h20, 32'hFFFF_FFFF);
    for (int o = 0; o < 4; o++) begin
      issue(1'b1, 3'b000, base + 32'h20 + 32'(o), 32'hDEAD_BE00 | 32'(o));
      issue(1'b0, 3'b010, base + 32'h20, '0);
    end
    issue(1'b1, 3'b010, base + 32'h24, 32'h0000_0000);
    for (int o = 0; o < 4; o += 2) begin
      issue(1'b1, 3'b001, base + 32'h24 + 32'(o), 32'hCAFE_1111 + 32'(o * 4369));
      issue(1'b0, 3'b010, base + 32'h24, '0);
    end

    // Sign and zero extension, negative and positive patterns
    issue(1'b1, 3'b010, base + 32'h30, 32'h8A7F_F005);
    issue(1'b1, 3'b010, base + 32'h34, 32'h7FFF_0180);
    for (int w = 0; w < 2; w++) begin
      for (int o = 0; o < 4; o++) begin
        issue(1'b0, 3'b000, base + 32'h30 + 32'(4 * w + o), '0);
        issue(1'b0, 3'b100, base + 32'h30 + 32'(4 * w + o), '0);
        if (o % 2 == 0) begin
          issue(1'b0, 3'b001, base + 32'h30 + 32'(4 * w + o), '0);
          issue(1'b0, 3'b101, base + 32'h30 + 32'(4 * w + o), '0);
        end
      end
    end

    // Misaligned, out of range and reserved codes
    issue(1'b0, 3'b001, base + 32'h31, '0);
    issue(1'b0, 3'b010, base + 32'h32, '0);
    issue(1'b0, 3'b010, base + 32'h31, '0);
    issue(1'b1, 3'b001, base + 32'h31, 32'hFFFF_FFFF);
    issue(1'b1, 3'b010, base + 32'h32, 32'hFFFF_FFFF);
    issue(1'b1, 3'b010, base + 32'h33, 32'hFFFF_FFFF);
    issue(1'b0, 3'b010, base + 32'h30, '0);
    issue(1'b0, 3'b010, base - 32'd4, '0);
    issue(1'b0, 3'b010, base + 32'(nbytes), '0);
    issue(1'b1, 3'b010, base - 32'd4, 32'h5555_5555);
    issue(1'b1, 3'b010, base + 32'(nbytes), 32'h5555_5555);
    issue(1'b0, 3'b011, base + 32'h30, '0);
    issue(1'b0, 3'b110, base + 32'h30, '0);
    issue(1'b0, 3'b111, base + 32'h30, '0);
    issue(1'b1, 3'b011, base + 32'h30, 32'h0);
    issue(1'b1, 3'b100, base + 32'h30, 32'h0);
    issue(1'b1, 3'b101, base + 32'h30, 32'h0);
    issue(1'b0, 3'b010, base + 32'h30, '0);

    // Random traffic, a few bytes past each end of the region
    for (int n = 0; n < n_random; n++) begin
      r = $random(seed);
      d = $random(seed);
      a = base - 32'd8 + (r % 32'(nbytes + 16));
      if (r[24]) begin
        a[1:0] = 2'b00;
      end
      if (r[27:26] == 2'b00) begin
        idle();
      end else begin
        issue(r[25], r[31:29], a, d);
      end
    end

    // Drain the load queue, then let the last store fault land
    idle();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    a_store_faults: assert (st_faults_seen == st_faults) else begin
      errors++;
      $display("Error at %0t: %0d store faults seen, %0d expected", $time,
               st_faults_seen, st_faults);
    end
    $display("Closing: %0d testbench errors, %0d assertion failures", errors,
             uut.u_assert.fail_count);
    if (errors == 0 && uut.u_assert.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
// RV32 data memory top level
// Four byte-lane banks between store steering and load formatting
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
  parameter logic [dmem_pkg::xlen-1:0] base_addr = 32'h8000_2000,
  parameter int depth_words = 1024
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      rd_en,
  input  logic                      wr_en,
  input  logic [2:0]                fn3,
  input  logic [dmem_pkg::xlen-1:0] addr,
  input  logic [dmem_pkg::xlen-1:0] wdata,
  output logic [dmem_pkg::xlen-1:0] rdata,
  output logic                      rvalid,
  output logic                      fault
);
  import dmem_pkg::*;

  mem_fn3_e   fn3_code;
  logic [7:0] lane_rdata [lanes];

  dmem_lane_if #(.depth_words(depth_words)) lane_if ();
  dmem_load_if #(.depth_words(depth_words)) load_if ();

  // Reserved codes pass through and are faulted by the decoder
  assign fn3_code = mem_fn3_e'(fn3);

  // --------------------
  // Request side
  // --------------------

  dmem_store_align #(
    .base_addr   (base_addr),
    .depth_words (depth_words)
  ) u_store_align (
    .clk    (clk),
    .arst_n (arst_n),
    .rd_en  (rd_en),
    .wr_en  (wr_en),
    .fn3    (fn3_code),
    .addr   (addr),
    .wdata  (wdata),
    .lane   (lane_if.steer),
    .ld     (load_if.ctx)
  );

  // --------------------
  // Banks
  // --------------------

  for (genvar i = 0; i < lanes; i++) begin : g_bank
    dmem_bank #(
      .lane_index  (i),
      .depth_words (depth_words)
    ) u_bank (
      .clk        (clk),
      .lane       (lane_if.bank),
      .rdata_byte (lane_rdata[i])
    );
  end

  // Lane k becomes byte k of the bank word
  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      load_if.rdata[8*k +: 8] = lane_rdata[k];
    end
  end

  // --------------------
  // Load side
  // --------------------

  dmem_load_format u_load_format (
    .clk    (clk),
    .arst_n (arst_n),
    .ld     (load_if.fmt),
    .rdata  (rdata),
    .rvalid (rvalid),
    .fault  (fault)
  );

endmodule

`default_nettype wire

// File: verilog/dmem_bank.sv
// One byte lane of the data memory
// Synchronous write by mask bit, registered read
`timescale 1ns/1ns
`default_nettype none

module dmem_bank #(
  parameter int lane_index  = 0,
  parameter int depth_words = 1024
) (
  input  logic       clk,
  dmem_lane_if.bank  lane,
  output logic [7:0] rdata_byte
);

  // Byte storage for this lane, maps onto a block RAM
  logic [7:0] mem [depth_words];

  // Read returns the old byte on a write to the same word
  always_ff @(posedge clk) begin
    if (lane.en) begin
      if (lane.we_mask[lane_index]) begin
        mem[lane.word_addr] <= lane.wdata[8*lane_index +: 8];
      end
      rdata_byte <= mem[lane.word_addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/dmem_lane_if.sv
// Bank request bus from the store steering to the byte-lane banks
// One request per cycle, no handshake
`timescale 1ns/1ns
`default_nettype none

interface dmem_lane_if #(
  parameter int depth_words = 1024
);
  import dmem_pkg::*;

  // Word address width follows the memory depth
  localparam int aw = $clog2(depth_words);

  // Any accepted access, load or store
  logic en;
  // One write bit per lane, empty for loads
  logic [lanes-1:0] we_mask;
  // Word index inside the region
  logic [aw-1:0] word_addr;
  // Byte k lands in lane k
  logic [xlen-1:0] wdata;

  // Steering side drives the request
  modport steer (
    output en,
    output we_mask,
    output word_addr,
    output wdata
  );

  // Every bank listens to the same request
  modport bank (
    input en,
    input we_mask,
    input word_addr,
    input wdata
  );

endinterface

`default_nettype wire

// File: verilog/dmem_load_format.sv
// Load result formatter
// Byte select, sign or zero extension and fault substitution
`timescale 1ns/1ns
`default_nettype none

module dmem_load_format (
  input  logic                      clk,
  input  logic                      arst_n,
  dmem_load_if.fmt                  ld,
  output logic [dmem_pkg::xlen-1:0] rdata,
  output logic                      rvalid,
  output logic                      fault
);
  import dmem_pkg::*;

  logic [xlen-1:0] shifted;
  logic [xlen-1:0] ext_word;
  logic [xlen-1:0] load_word;

  // --------------------
  // Extraction
  // --------------------

  // Bring the addressed byte down to bit 0
  assign shifted = ld.rdata >> {ld.ld_offset, 3'b000};

  always_comb begin
    case (ld.ld_fn3)
      // Signed byte
      FN3_B:  ext_word = {{(xlen-8){shifted[7]}}, shifted[7:0]};
      FN3_BU: ext_word = {{(xlen-8){1'b0}}, shifted[7:0]};
      // Signed halfword
      FN3_H:  ext_word = {{(xlen-16){shifted[15]}}, shifted[15:0]};
      FN3_HU: ext_word = {{(xlen-16){1'b0}}, shifted[15:0]};
      FN3_W:  ext_word = shifted;
      // Reserved codes are already faulted upstream
      default: ext_word = fault_data;
    endcase
  end

  assign load_word = ld.ld_fault ? fault_data : ext_word;

  // --------------------
  // Output register
  // --------------------

  // rvalid and fault pulse for one cycle
  // rdata holds between loads
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
      fault  <= 1'b0;
      rdata  <= '0;
    end else begin
      rvalid <= ld.ld_valid;
      fault  <= ld.ld_fault;
      if (ld.ld_valid) begin
        rdata <= load_word;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dmem_load_if.sv
// Load path bus into the formatter
// Bank read word plus the load context registered with the request
`timescale 1ns/1ns
`default_nettype none

interface dmem_load_if #(
  parameter int depth_words = 1024
);
  import dmem_pkg::*;

  // Bank word, assembled from the lane outputs
  logic [xlen-1:0] rdata;

  // Context registered on the request edge
  logic ld_valid;
  mem_fn3_e ld_fn3;
  // Byte offset inside the word
  logic [1:0] ld_offset;
  // Request was refused, load or store
  logic ld_fault;

  // Steering side drives the context
  modport ctx (
    output ld_valid,
    output ld_fn3,
    output ld_offset,
    output ld_fault
  );

  // Formatter reads everything
  modport fmt (
    input rdata,
    input ld_valid,
    input ld_fn3,
    input ld_offset,
    input ld_fault
  );

endinterface

`default_nettype wire

// File: verilog/dmem_pkg.sv
// Data memory shared definitions
// Widths, lane count, funct3 access codes and fault pattern
`default_nettype none

package dmem_pkg;

  // --------------------
  // Widths
  // --------------------

  // Data and address width of the RV32 core
  localparam int xlen = 32;

  // Byte lanes per 32-bit word
  localparam int lanes = 4;

  // --------------------
  // Access codes
  // --------------------

  // RISC-V funct3 for loads and stores
  // Stores only use the B, H and W codes
  typedef enum logic [2:0] {
    FN3_B  = 3'b000,
    FN3_H  = 3'b001,
    FN3_W  = 3'b010,
    FN3_BU = 3'b100,
    FN3_HU = 3'b101
  } mem_fn3_e;

  // --------------------
  // Fault response
  // --------------------

  // Returned for any refused or illegal load
  // Easy to spot in a waveform
  localparam logic [xlen-1:0] fault_data = 32'hABCD_EF12;

endpackage

`default_nettype wire

// File: verilog/dmem_store_align.sv
// Data memory request decode
// Address check, store lane steering and load context register
`timescale 1ns/1ns
`default_nettype none

module dmem_store_align #(
  parameter logic [dmem_pkg::xlen-1:0] base_addr = 32'h8000_2000,
  parameter int depth_words = 1024
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      rd_en,
  input  logic                      wr_en,
  input  dmem_pkg::mem_fn3_e        fn3,
  input  logic [dmem_pkg::xlen-1:0] addr,
  input  logic [dmem_pkg::xlen-1:0] wdata,
  dmem_lane_if.steer                lane,
  dmem_load_if.ctx                  ld
);
  import dmem_pkg::*;

  localparam int aw = $clog2(depth_words);

  logic [xlen-1:0]   off_addr;
  logic [1:0]        byte_off;
  logic              in_range;
  logic              aligned;
  logic              legal_ld;
  logic              legal_st;
  logic              fn3_ok;
  logic              req;
  logic              accept;
  logic [lanes-1:0]  size_mask;
  logic [2*xlen-1:0] wdata_rot;

  // --------------------
  // Address decode
  // --------------------

  // Below base wraps to a huge offset, so one compare covers both ends
  assign off_addr = addr - base_addr;
  assign byte_off = off_addr[1:0];
  assign in_range = (off_addr[xlen-1:aw+2] == '0);

  // Size, alignment and legality per funct3
  always_comb begin
    aligned   = 1'b0;
    legal_ld  = 1'b1;
    legal_st  = 1'b0;
    size_mask = '0;
    case (fn3)
      FN3_B: begin
        aligned   = 1'b1;
        legal_st  = 1'b1;
        size_mask = 4'b0001;
      end
      FN3_BU: begin
        aligned   = 1'b1;
        size_mask = 4'b0001;
      end
      FN3_H: begin
        aligned   = ~byte_off[0];
        legal_st  = 1'b1;
        size_mask = 4'b0011;
      end
      FN3_HU: begin
        aligned   = ~byte_off[0];
        size_mask = 4'b0011;
      end
      FN3_W: begin
        aligned   = (byte_off == 2'b00);
        legal_st  = 1'b1;
        size_mask = 4'b1111;
      end
      // Codes 011, 110, 111 are reserved
      default: legal_ld = 1'b0;
    endcase
  end

  assign fn3_ok = wr_en ? legal_st : legal_ld;
  assign req    = rd_en | wr_en;
  assign accept = req & in_range & aligned & fn3_ok;

  // --------------------
  // Bank request
  // --------------------

  // Rotate left by the byte offset so byte 0 meets its lane
  assign wdata_rot = {wdata, wdata} << {byte_off, 3'b000};

  assign lane.en        = accept;
  // Loads read with an empty mask
  assign lane.we_mask   = (accept && wr_en) ? (size_mask << byte_off) : '0;
  assign lane.word_addr = off_addr[aw+1:2];
  assign lane.wdata     = wdata_rot[2*xlen-1:xlen];

  // --------------------
  // Load context
  // --------------------

  // Fault is flagged for refused loads and stores alike
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ld.ld_valid <= 1'b0;
      ld.ld_fault <= 1'b0;
    end else begin
      ld.ld_valid <= rd_en;
      ld.ld_fault <= req & ~accept;
    end
  end

  // Only meaningful while ld_valid is set
  always_ff @(posedge clk) begin
    ld.ld_fn3    <= fn3;
    ld.ld_offset <= byte_off;
  end

endmodule

`default_nettype wire
